//--- logic/tart_cfg.svh
`ifndef TART_CFG_SVH
`define TART_CFG_SVH

// ----------------------------------------------------------------------
// Front-end sizing
// ----------------------------------------------------------------------

// Antenna inputs, one bit each per sample
`define TART_ANTENNAE 24

// Clock cycles between sample strobes
`define TART_TMUX_RATE 12

// Sample buffer entries in the acquisition unit
`define TART_ACQ_DEPTH 16

// ----------------------------------------------------------------------
// Fake data and reset
// ----------------------------------------------------------------------

// LFSR start value, must be non-zero
`define TART_LFSR_SEED 24'h000001

// Software reset pulse length in cycles
`define TART_RESET_TICKS 4

// Read value of the empty DSP slot
`define TART_UNMAPPED_DATA 8'hce

`endif

//--- logic/tart_pkg.sv
`default_nettype none

`include "tart_cfg.svh"

package tart_pkg;

    // ------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------
    typedef logic [`TART_ANTENNAE-1:0]          antenna_t;   // All antennas, one sample
    typedef logic [7:0]                         bus_data_t;  // Register bus byte
    typedef logic [1:0]                         unit_sel_t;  // 00 cap, 01 acq, 10 none, 11 ctl
    typedef logic [1:0]                         reg_adr_t;   // Register inside a unit
    typedef logic [$clog2(`TART_ACQ_DEPTH)-1:0] acq_index_t; // Buffer slot
    typedef logic [1:0]                         byte_sel_t;  // Byte of a sample, 0..2

    // ------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------

    // Host request, held stable by the host while req is up
    typedef struct packed {
        logic      we;
        unit_sel_t sel;
        reg_adr_t  adr;
        bus_data_t wdata;
    } host_req_t;

    // Single-cycle access into one unit
    typedef struct packed {
        logic      stb;
        logic      we;
        reg_adr_t  adr;
        bus_data_t wdata;
    } unit_access_t;

    // Capture to acquire sample path
    typedef struct packed {
        logic     strobe;
        antenna_t data;
    } sample_t;

    // Unit flags gathered for the control status register
    typedef struct packed {
        logic cap_enabled;
        logic cap_debug;
        logic acq_armed;
        logic acq_full;
    } unit_status_t;

    // Host port handshake FSM
    typedef enum logic [1:0] {
        IDLE,
        RESPOND,
        WAIT_DROP
    } host_state_e;

endpackage

`default_nettype wire

//--- logic/tart_bus_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "tart_cfg.svh"

module tart_bus_decode (
    input  wire logic                   clock_b,
    input  wire logic                   rst_n_i,
    // Host four-phase port
    input  wire logic                   req_i,
    input  wire tart_pkg::host_req_t    host_req_i,
    output logic                        ack_o,
    output tart_pkg::bus_data_t         rdata_o,
    // Unit accesses
    output tart_pkg::unit_access_t      cap_acc_o,
    output tart_pkg::unit_access_t      acq_acc_o,
    output tart_pkg::unit_access_t      ctl_acc_o,
    input  wire tart_pkg::bus_data_t    cap_rdata_i,
    input  wire tart_pkg::bus_data_t    acq_rdata_i,
    input  wire tart_pkg::bus_data_t    ctl_rdata_i
);

    localparam tart_pkg::unit_sel_t SEL_CAP = 2'b00;
    localparam tart_pkg::unit_sel_t SEL_ACQ = 2'b01;
    localparam tart_pkg::unit_sel_t SEL_CTL = 2'b11; // 10 is the empty DSP slot

    tart_pkg::host_state_e  state_q;
    tart_pkg::host_req_t    req_q;    // Latched copy of the request
    tart_pkg::unit_access_t acc_base; // Shared fields, strobe decoded below

    // ------------------------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i) begin
            state_q <= tart_pkg::IDLE;
            ack_o   <= 1'b0;
            rdata_o <= '0;
        end else begin
            case (state_q)
                tart_pkg::IDLE: begin
                    if (req_i) begin
                        state_q <= tart_pkg::RESPOND; // Strobe goes out next cycle
                    end
                end
                tart_pkg::RESPOND: begin
                    ack_o   <= 1'b1;
                    state_q <= tart_pkg::WAIT_DROP;
                    case (req_q.sel)                  // Unit answers in strobe cycle
                        SEL_CAP: rdata_o <= cap_rdata_i;
                        SEL_ACQ: rdata_o <= acq_rdata_i;
                        SEL_CTL: rdata_o <= ctl_rdata_i;
                        default: rdata_o <= `TART_UNMAPPED_DATA;
                    endcase
                end
                tart_pkg::WAIT_DROP: begin
                    if (!req_i) begin                 // Host let go, finish phase 4
                        ack_o   <= 1'b0;
                        state_q <= tart_pkg::IDLE;
                    end
                end
                default: state_q <= tart_pkg::IDLE;
            endcase
        end
    end

    // Request payload, captured as the access starts
    always_ff @(posedge clock_b) begin
        if (state_q == tart_pkg::IDLE && req_i) begin
            req_q <= host_req_i;
        end
    end

    assign acc_base.stb   = (state_q == tart_pkg::RESPOND); // One cycle per access
    assign acc_base.we    = req_q.we;
    assign acc_base.adr   = req_q.adr;
    assign acc_base.wdata = req_q.wdata;

    // Only the selected unit sees the strobe
    always_comb begin
        cap_acc_o     = acc_base;
        acq_acc_o     = acc_base;
        ctl_acc_o     = acc_base;
        cap_acc_o.stb = acc_base.stb && (req_q.sel == SEL_CAP);
        acq_acc_o.stb = acc_base.stb && (req_q.sel == SEL_ACQ);
        ctl_acc_o.stb = acc_base.stb && (req_q.sel == SEL_CTL);
    end

    // ack only follows a request seen on the edge before
    a_ack_needs_req: assert property (
        @(posedge clock_b) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i)
    ) else $error("ack_o rose without req_i");

endmodule

`default_nettype wire

//--- logic/tart_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "tart_cfg.svh"

module tart_capture (
    input  wire logic                   clock_b,
    input  wire logic                   rst_n_i,
    input  wire logic                   soft_rst_i,
    input  wire tart_pkg::antenna_t     antenna_i,
    input  wire tart_pkg::unit_access_t acc_i,
    output tart_pkg::bus_data_t         rdata_o,
    output tart_pkg::sample_t           sample_o,
    output logic                        enabled_o,
    output logic                        debug_o
);

    localparam int TICK_BITS = $clog2(`TART_TMUX_RATE);
    localparam logic [TICK_BITS-1:0] TICK_LAST = TICK_BITS'(`TART_TMUX_RATE - 1);
    // Galois taps 24,23,22,17
    localparam tart_pkg::antenna_t LFSR_MASK = 24'he10000;

    logic                  enable_q;
    logic                  debug_q;
    logic [TICK_BITS-1:0]  tick_q;    // TMUX phase
    logic                  strobe_q;
    tart_pkg::antenna_t    data_q;    // Sample payload
    tart_pkg::antenna_t    lfsr_q;
    tart_pkg::antenna_t    lfsr_next;
    logic                  wrap;      // Last tick of the period
    logic                  ctl_wr;

    assign ctl_wr    = acc_i.stb && acc_i.we && (acc_i.adr == 2'd0);
    assign wrap      = enable_q && (tick_q == TICK_LAST);
    assign lfsr_next = {1'b0, lfsr_q[23:1]} ^ (lfsr_q[0] ? LFSR_MASK : '0);

    // ------------------------------------------------------------------
    // Controls, TMUX counter and fake data
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i || soft_rst_i) begin
            enable_q <= 1'b0;
            debug_q  <= 1'b0;
            tick_q   <= '0;
            strobe_q <= 1'b0;
            lfsr_q   <= `TART_LFSR_SEED;
        end else begin
            if (ctl_wr) begin
                enable_q <= acc_i.wdata[0];
                debug_q  <= acc_i.wdata[1];
            end
            if (!enable_q || wrap) begin
                tick_q <= '0;              // Period restarts on enable
            end else begin
                tick_q <= tick_q + 1'b1;
            end
            strobe_q <= wrap;
            if (!debug_q) begin
                lfsr_q <= `TART_LFSR_SEED; // Held at seed until debug
            end else if (wrap) begin
                lfsr_q <= lfsr_next;       // One step per sample
            end
        end
    end

    // Sample payload, either live antennas or LFSR
    always_ff @(posedge clock_b) begin
        if (wrap) begin
            data_q <= debug_q ? lfsr_q : antenna_i;
        end
    end

    assign sample_o.strobe = strobe_q;
    assign sample_o.data   = data_q;
    assign enabled_o       = enable_q;
    assign debug_o         = debug_q;

    // Only register 0 is populated
    assign rdata_o = (acc_i.adr == 2'd0) ? {6'd0, debug_q, enable_q} : '0;

    a_strobe_single: assert property (
        @(posedge clock_b) disable iff (!rst_n_i)
        sample_o.strobe |=> !sample_o.strobe
    ) else $error("Sample strobe high on two cycles in a row");

endmodule

`default_nettype wire

//--- logic/tart_acquire.sv
`timescale 1ns/100ps
`default_nettype none

`include "tart_cfg.svh"

module tart_acquire (
    input  wire logic                   clock_b,
    input  wire logic                   rst_n_i,
    input  wire logic                   soft_rst_i,
    input  wire tart_pkg::sample_t      sample_i,
    input  wire tart_pkg::unit_access_t acc_i,
    output tart_pkg::bus_data_t         rdata_o,
    output logic                        armed_o,
    output logic                        full_o
);

    localparam tart_pkg::acq_index_t IDX_LAST = tart_pkg::acq_index_t'(`TART_ACQ_DEPTH - 1);
    localparam tart_pkg::byte_sel_t  BYTE_LAST = 2'd2; // Three bytes per sample

    tart_pkg::antenna_t   sample_mem [`TART_ACQ_DEPTH];
    logic                 armed_q;
    logic                 full_q;
    tart_pkg::acq_index_t wr_idx_q;   // Next slot to fill
    tart_pkg::acq_index_t rd_idx_q;   // Read-back slot
    tart_pkg::byte_sel_t  byte_q;     // Read-back byte
    tart_pkg::bus_data_t  rd_byte;
    logic                 arm_wr;
    logic                 idx_wr;
    logic                 data_rd;
    logic                 store;

    assign arm_wr  = acc_i.stb &&  acc_i.we && (acc_i.adr == 2'd0) && acc_i.wdata[0];
    assign idx_wr  = acc_i.stb &&  acc_i.we && (acc_i.adr == 2'd1);
    assign data_rd = acc_i.stb && !acc_i.we && (acc_i.adr == 2'd2);
    assign store   = armed_q && sample_i.strobe;

    // ------------------------------------------------------------------
    // Fill control
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i || soft_rst_i) begin
            armed_q  <= 1'b0;
            full_q   <= 1'b0;
            wr_idx_q <= '0;
        end else if (arm_wr) begin
            armed_q  <= 1'b1;  // Re-arm drops any old burst
            full_q   <= 1'b0;
            wr_idx_q <= '0;
        end else if (store) begin
            wr_idx_q <= wr_idx_q + 1'b1;
            if (wr_idx_q == IDX_LAST) begin
                armed_q <= 1'b0; // Burst complete
                full_q  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_b) begin
        if (store && !arm_wr) begin
            sample_mem[wr_idx_q] <= sample_i.data;
        end
    end

    // ------------------------------------------------------------------
    // Byte-wise read-back
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i || soft_rst_i) begin
            rd_idx_q <= '0;
            byte_q   <= '0;
        end else if (idx_wr) begin
            rd_idx_q <= acc_i.wdata[$bits(tart_pkg::acq_index_t)-1:0];
            byte_q   <= '0;
        end else if (data_rd) begin
            if (byte_q == BYTE_LAST) begin
                byte_q   <= '0;
                rd_idx_q <= rd_idx_q + 1'b1; // On to the next sample
            end else begin
                byte_q   <= byte_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (byte_q)                        // Low byte first
            2'd0:    rd_byte = sample_mem[rd_idx_q][7:0];
            2'd1:    rd_byte = sample_mem[rd_idx_q][15:8];
            2'd2:    rd_byte = sample_mem[rd_idx_q][23:16];
            default: rd_byte = '0;
        endcase
    end

    always_comb begin
        case (acc_i.adr)
            2'd0:    rdata_o = {6'd0, full_q, armed_q};
            2'd1:    rdata_o = tart_pkg::bus_data_t'(rd_idx_q);
            2'd2:    rdata_o = rd_byte;
            default: rdata_o = tart_pkg::bus_data_t'(wr_idx_q); // Fill level
        endcase
    end

    assign armed_o = armed_q;
    assign full_o  = full_q;

    // A full buffer only changes by re-arming
    a_no_store_full: assert property (
        @(posedge clock_b) disable iff (!rst_n_i)
        full_q && sample_i.strobe |=> $stable(wr_idx_q) || $past(arm_wr)
    ) else $error("Sample stored while buffer full");

endmodule

`default_nettype wire

//--- logic/tart_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "tart_cfg.svh"

module tart_control (
    input  wire logic                   clock_b,
    input  wire logic                   rst_n_i,
    input  wire tart_pkg::unit_access_t acc_i,
    input  wire tart_pkg::unit_status_t status_i,
    output tart_pkg::bus_data_t         rdata_o,
    output logic                        soft_rst_o
);

    localparam int RST_BITS = $clog2(`TART_RESET_TICKS + 1);
    localparam logic [RST_BITS-1:0] RST_LOAD = RST_BITS'(`TART_RESET_TICKS);

    logic [RST_BITS-1:0] rst_cnt_q;  // Cycles of soft reset left
    tart_pkg::bus_data_t scratch_q;
    logic                rst_wr;
    logic                scratch_wr;

    assign rst_wr     = acc_i.stb && acc_i.we && (acc_i.adr == 2'd0) && acc_i.wdata[0];
    assign scratch_wr = acc_i.stb && acc_i.we && (acc_i.adr == 2'd1);

    // ------------------------------------------------------------------
    // Software reset pulse
    // ------------------------------------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i) begin
            rst_cnt_q <= '0;
        end else if (rst_wr && rst_cnt_q == '0) begin
            rst_cnt_q <= RST_LOAD;          // Ignored while a pulse runs
        end else if (rst_cnt_q != '0) begin
            rst_cnt_q <= rst_cnt_q - 1'b1;
        end
    end

    assign soft_rst_o = (rst_cnt_q != '0);

    // Scratch byte, outside the soft reset domain
    always_ff @(posedge clock_b) begin
        if (!rst_n_i) begin
            scratch_q <= '0;
        end else if (scratch_wr) begin
            scratch_q <= acc_i.wdata;
        end
    end

    always_comb begin
        case (acc_i.adr)
            2'd0:    rdata_o = {4'd0, status_i}; // en dbg armed full
            2'd1:    rdata_o = scratch_q;
            default: rdata_o = '0;
        endcase
    end

    // Pulse ends after the configured length
    a_soft_rst_len: assert property (
        @(posedge clock_b) disable iff (!rst_n_i)
        $rose(soft_rst_o) |-> ##(`TART_RESET_TICKS) !soft_rst_o
    ) else $error("soft_rst_o held longer than the reset length");

endmodule

`default_nettype wire

//--- logic/tart_top.sv
`timescale 1ns/100ps
`default_nettype none

module tart_top (
    input  wire logic                clock_b,
    input  wire logic                rst_n_i,
    input  wire logic                req_i,
    input  wire tart_pkg::host_req_t host_req_i,
    input  wire tart_pkg::antenna_t  antenna_i,
    output logic                     ack_o,
    output tart_pkg::bus_data_t      rdata_o
);

    // ------------------------------------------------------------------
    // Interconnect
    // ------------------------------------------------------------------
    tart_pkg::unit_access_t cap_acc;
    tart_pkg::unit_access_t acq_acc;
    tart_pkg::unit_access_t ctl_acc;
    tart_pkg::bus_data_t    cap_rdata;
    tart_pkg::bus_data_t    acq_rdata;
    tart_pkg::bus_data_t    ctl_rdata;
    tart_pkg::sample_t      sample;      // Capture to acquire
    tart_pkg::unit_status_t status;
    logic                   soft_rst;    // From control, to cap and acq
    logic                   cap_enabled;
    logic                   cap_debug;
    logic                   acq_armed;
    logic                   acq_full;

    assign status = tart_pkg::unit_status_t'{
        cap_enabled: cap_enabled,
        cap_debug:   cap_debug,
        acq_armed:   acq_armed,
        acq_full:    acq_full
    };

    tart_bus_decode u_bus_decode (
        .clock_b     (clock_b),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .host_req_i  (host_req_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .cap_acc_o   (cap_acc),
        .acq_acc_o   (acq_acc),
        .ctl_acc_o   (ctl_acc),
        .cap_rdata_i (cap_rdata),
        .acq_rdata_i (acq_rdata),
        .ctl_rdata_i (ctl_rdata)
    );

    tart_capture u_capture (
        .clock_b    (clock_b),
        .rst_n_i    (rst_n_i),
        .soft_rst_i (soft_rst),
        .antenna_i  (antenna_i),
        .acc_i      (cap_acc),
        .rdata_o    (cap_rdata),
        .sample_o   (sample),
        .enabled_o  (cap_enabled),
        .debug_o    (cap_debug)
    );

    tart_acquire u_acquire (
        .clock_b    (clock_b),
        .rst_n_i    (rst_n_i),
        .soft_rst_i (soft_rst),
        .sample_i   (sample),
        .acc_i      (acq_acc),
        .rdata_o    (acq_rdata),
        .armed_o    (acq_armed),
        .full_o     (acq_full)
    );

    tart_control u_control (
        .clock_b    (clock_b),
        .rst_n_i    (rst_n_i),
        .acc_i      (ctl_acc),
        .status_i   (status),
        .rdata_o    (ctl_rdata),
        .soft_rst_o (soft_rst)
    );

endmodule

`default_nettype wire

//--- sim/tart_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tart_cfg.svh"

module tart_tb;

    // ------------------------------------------------------------------
    // Run length and limits
    // ------------------------------------------------------------------
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int HS_CYCLES    = 6;   // Rough cost of one host access
    localparam int HS_TIMEOUT   = 20;  // Cycles to wait for one ack edge
    localparam int BURST_CYCLES = `TART_ACQ_DEPTH * `TART_TMUX_RATE;
    localparam int READ_CYCLES  = 3 * `TART_ACQ_DEPTH * HS_CYCLES;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * (BURST_CYCLES + READ_CYCLES)
                                  + 40 * HS_CYCLES;
    localparam int POLL_LIMIT   = 2 * BURST_CYCLES / HS_CYCLES;

    localparam tart_pkg::unit_sel_t SEL_CAP  = 2'b00;
    localparam tart_pkg::unit_sel_t SEL_ACQ  = 2'b01;
    localparam tart_pkg::unit_sel_t SEL_NONE = 2'b10; // Former DSP slot
    localparam tart_pkg::unit_sel_t SEL_CTL  = 2'b11;

    logic                clock_b;
    logic                rst_n_i;
    logic                req_i;
    tart_pkg::host_req_t host_req_i;
    tart_pkg::antenna_t  antenna_i;
    logic                ack_o;
    tart_pkg::bus_data_t rdata_o;

    tart_pkg::antenna_t  sample_buf [`TART_ACQ_DEPTH]; // Read-back of one burst
    int                  err_count   = 0;
    int                  check_count = 0;
    integer              seed        = 32'hcda7_1f81;

    tart_top u_tart_top (
        .clock_b    (clock_b),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .host_req_i (host_req_i),
        .antenna_i  (antenna_i),
        .ack_o      (ack_o),
        .rdata_o    (rdata_o)
    );

    initial begin
        clock_b = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock_b = ~clock_b;
        end
    end

    // ------------------------------------------------------------------
    // Host port protocol checks
    // ------------------------------------------------------------------
    a_ack_timing: assert property (@(posedge clock_b) disable iff (!rst_n_i)
        $rose(req_i) |-> !ack_o ##1 !ack_o ##1 ack_o)
        else begin
            err_count++;
            $display("ack_o was not high two edges after req_i at %0t ns", $time);
        end

    a_ack_hold: assert property (@(posedge clock_b) disable iff (!rst_n_i)
        ack_o && req_i |=> ack_o)
        else begin
            err_count++;
            $display("ack_o dropped while req_i was still held at %0t ns", $time);
        end

    a_rdata_stable: assert property (@(posedge clock_b) disable iff (!rst_n_i)
        ack_o && $past(ack_o) |-> $stable(rdata_o))
        else begin
            err_count++;
            $display("rdata_o changed while ack_o was high at %0t ns", $time);
        end

    a_ack_fall: assert property (@(posedge clock_b) disable iff (!rst_n_i)
        $fell(req_i) |-> ack_o ##1 !ack_o)
        else begin
            err_count++;
            $display("ack_o did not fall one edge after req_i dropped at %0t ns", $time);
        end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            err_count++;
            $display("ERROR at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    // Polls ack_o on falling edges
    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack_o !== level && n < HS_TIMEOUT) begin
            @(negedge clock_b);
            n++;
        end
        if (ack_o !== level) begin
            err_count++;
            $display("Host port timed out waiting for ack_o to go %0b at %0t ns",
                     level, $time);
        end
    endtask

    // Full four-phase cycle, req held hold extra cycles after ack
    task automatic host_access(input logic we, input tart_pkg::unit_sel_t sel,
                               input tart_pkg::reg_adr_t adr,
                               input tart_pkg::bus_data_t wdata, input int hold,
                               output tart_pkg::bus_data_t rdata);
        @(negedge clock_b);
        host_req_i.we    = we;
        host_req_i.sel   = sel;
        host_req_i.adr   = adr;
        host_req_i.wdata = wdata;
        req_i            = 1'b1;
        @(negedge clock_b);              // First edge has seen req
        wait_ack(1'b1);
        rdata = rdata_o;
        repeat (hold) @(negedge clock_b);
        req_i = 1'b0;
        wait_ack(1'b0);                  // Phase 4 done
    endtask

    task automatic host_write(input tart_pkg::unit_sel_t sel, input tart_pkg::reg_adr_t adr,
                              input tart_pkg::bus_data_t wdata);
        tart_pkg::bus_data_t unused;
        host_access(1'b1, sel, adr, wdata, 0, unused);
    endtask

    task automatic host_read(input tart_pkg::unit_sel_t sel, input tart_pkg::reg_adr_t adr,
                             output tart_pkg::bus_data_t rdata);
        host_access(1'b0, sel, adr, 8'h00, 0, rdata);
    endtask

    // Acquire status bit 1 is full
    task automatic wait_full();
        tart_pkg::bus_data_t st;
        int polls;
        st    = '0;
        polls = 0;
        while (st[1] !== 1'b1 && polls < POLL_LIMIT) begin
            host_read(SEL_ACQ, 2'd0, st);
            polls++;
        end
        if (st[1] !== 1'b1) begin
            err_count++;
            $display("Acquire buffer never reported full at %0t ns", $time);
        end
    endtask

    // Three bytes per sample, low byte first
    task automatic read_buffer();
        tart_pkg::bus_data_t b;
        host_write(SEL_ACQ, 2'd1, 8'h00);
        for (int i = 0; i < `TART_ACQ_DEPTH; i++) begin
            for (int k = 0; k < 3; k++) begin
                host_read(SEL_ACQ, 2'd2, b);
                sample_buf[i][8*k +: 8] = b;
            end
        end
    endtask

    // Galois LFSR, taps 24,23,22,17, shifting right
    function automatic tart_pkg::antenna_t lfsr_advance(input tart_pkg::antenna_t state);
        int taps [4] = '{24, 23, 22, 17};
        tart_pkg::antenna_t mask;
        mask = '0;
        foreach (taps[i]) begin
            mask[taps[i]-1] = 1'b1;
        end
        return (state >> 1) ^ (state[0] ? mask : '0);
    endfunction

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        tart_pkg::antenna_t  pattern;
        tart_pkg::bus_data_t rd;
        tart_pkg::bus_data_t scratch;
        req_i      = 1'b0;
        host_req_i = '0;
        antenna_i  = '0;
        rst_n_i    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock_b);
        rst_n_i = 1'b1;
        @(negedge clock_b);
        check_value("ack_o", 32'd0, ack_o);
        check_value("rdata_o", 32'd0, rdata_o);

        // Handshake with req held a while, capture idle
        host_access(1'b0, SEL_CAP, 2'd0, 8'h00, 3, rd);
        check_value("capture reg0", 8'h00, rd);

        // Live capture of one held pattern
        pattern = tart_pkg::antenna_t'($random(seed));
        @(negedge clock_b);
        antenna_i = pattern;
        host_write(SEL_CAP, 2'd0, 8'h01);     // Enable, debug off
        host_write(SEL_ACQ, 2'd0, 8'h01);     // Arm
        wait_full();
        host_read(SEL_ACQ, 2'd0, rd);
        check_value("acquire reg0", 8'h02, rd);  // Full, not armed
        read_buffer();
        for (int i = 0; i < `TART_ACQ_DEPTH; i++) begin
            check_value("live sample", pattern, sample_buf[i]);
        end

        // Fake data from the LFSR
        host_write(SEL_CAP, 2'd0, 8'h03);
        host_write(SEL_ACQ, 2'd0, 8'h01);
        wait_full();
        read_buffer();
        check_count++;
        assert (sample_buf[0] != '0) else begin
            err_count++;
            $display("First fake sample is all zero at %0t ns, no LFSR data", $time);
        end
        for (int i = 1; i < `TART_ACQ_DEPTH; i++) begin
            check_value("fake sample", lfsr_advance(sample_buf[i-1]), sample_buf[i]);
        end

        // Scratch, status and the empty slot
        scratch = tart_pkg::bus_data_t'($random(seed)) | 8'h01; // Never the reset value
        host_write(SEL_CTL, 2'd1, scratch);
        host_read(SEL_CTL, 2'd1, rd);
        check_value("scratch", scratch, rd);
        host_read(SEL_CTL, 2'd0, rd);
        check_value("control status", {4'b0, 1'b1, 1'b1, 1'b0, 1'b1}, rd); // en dbg armed full
        host_read(SEL_NONE, 2'd0, rd);
        check_value("unmapped slot", 8'hce, rd);
        host_write(SEL_NONE, 2'd0, 8'h00);   // Goes nowhere
        host_read(SEL_CAP, 2'd0, rd);
        check_value("capture reg0", 8'h03, rd);

        // Software reset
        host_write(SEL_CTL, 2'd0, 8'h01);
        repeat (`TART_RESET_TICKS + 2) @(negedge clock_b);
        host_read(SEL_CAP, 2'd0, rd);
        check_value("capture reg0", 8'h00, rd);
        host_read(SEL_ACQ, 2'd0, rd);
        check_value("acquire reg0", 8'h00, rd);
        host_read(SEL_CTL, 2'd1, rd);
        check_value("scratch", scratch, rd);  // Survives soft reset
        host_read(SEL_CTL, 2'd0, rd);
        check_value("control status", 8'h00, rd);

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Twice the expected run length
    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", 2 * TEST_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/tart_pkg.sv
logic/tart_bus_decode.sv
logic/tart_capture.sv
logic/tart_acquire.sv
logic/tart_control.sv
logic/tart_top.sv
sim/tart_tb.sv

//--- Bender.yml
package:
  name: tart_frontend

sources:
  - include_dirs:
      - logic
    files:
      - logic/tart_pkg.sv
      - logic/tart_bus_decode.sv
      - logic/tart_capture.sv
      - logic/tart_acquire.sv
      - logic/tart_control.sv
      - logic/tart_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/tart_tb.sv
